//--- hdl/swp_pkg.sv
package swp_pkg;

  localparam int QPN_W         = 6;
  localparam int NUM_QP        = 64;
  localparam int IDX_W         = 16;
  localparam int RING_W        = 8;
  localparam int QP_SQ_SHIFT   = 14;
  localparam int WQE_LOG2_MAX  = 6;
  localparam int DB_FIFO_DEPTH = 8;
  localparam int WP_FIFO_DEPTH = 2;
  localparam int REQ_CREDITS   = 4;
  localparam int CFG_ADDR_W    = 2;

  // Register field widths
  localparam int LOG2_W        = 3;
  localparam int QUANT_W       = 4;

  // Credit counters must hold their full value
  localparam int WP_CRED_W     = $clog2(WP_FIFO_DEPTH + 1);
  localparam int REQ_CRED_W    = $clog2(REQ_CREDITS + 1);

  typedef struct packed {
    logic [QPN_W-1:0] qpn;
    logic [IDX_W-1:0] pi;
  } db_t;

  typedef struct packed {
    logic [QPN_W-1:0] qpn;
    logic [IDX_W-1:0] start;
    logic [IDX_W-1:0] count;
  } job_t;

  typedef struct packed {
    logic [QPN_W-1:0] qpn;
    logic [IDX_W-1:0] idx;
    logic             last;
  } wqe_desc_t;

  typedef struct packed {
    logic [QPN_W-1:0] qpn;
    logic [IDX_W-1:0] idx;
    logic [31:0]      addr;
    logic             last;
  } req_t;

  typedef struct packed {
    logic [31:0]        sq_base;
    logic [LOG2_W-1:0]  wqe_log2;
    logic [QUANT_W-1:0] quantum;
  } cfg_t;

endpackage

//--- hdl/swp_fifo.sv
`timescale 1ns/1ns

module swp_fifo #(
  parameter type T     = logic,
  parameter int  DEPTH = 4
) (
  input  logic i_clk,
  input  logic i_rst,
  input  logic i_push,
  input  T     i_data,
  input  logic i_pop,
  output T     o_data,
  output logic o_valid,
  output logic o_credit
);

  localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
  localparam int CNT_W = $clog2(DEPTH + 1);

  T                 mem [DEPTH];
  logic [PTR_W-1:0] wr_ptr;
  logic [PTR_W-1:0] rd_ptr;
  logic [CNT_W-1:0] count;
  logic             do_push;
  logic             do_pop;

  function automatic logic [PTR_W-1:0] ptr_inc(input logic [PTR_W-1:0] p);
    return (p == PTR_W'(DEPTH - 1)) ? '0 : p + 1'b1;
  endfunction

  assign do_pop  = i_pop && (count != '0);
  // A full FIFO still takes a push in the cycle it pops
  assign do_push = i_push && ((count != CNT_W'(DEPTH)) || do_pop);

  always_ff @(posedge i_clk) begin
    if (do_push) begin
      mem[wr_ptr] <= i_data;
    end
  end

  always_ff @(posedge i_clk) begin
    if (i_rst) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (do_push) begin
        wr_ptr <= ptr_inc(wr_ptr);
      end
      if (do_pop) begin
        rd_ptr <= ptr_inc(rd_ptr);
      end
      case ({do_push, do_pop})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: ;
      endcase
    end
  end

  assign o_data   = mem[rd_ptr];
  assign o_valid  = (count != '0);
  assign o_credit = do_pop;

endmodule

//--- hdl/swp_cfg_regs.sv
`timescale 1ns/1ns

module swp_cfg_regs
  import swp_pkg::*;
(
  input  logic                  i_clk,
  input  logic                  i_rst,
  input  logic                  i_cfg_we,
  input  logic [CFG_ADDR_W-1:0] i_cfg_addr,
  input  logic [31:0]           i_cfg_wdata,
  output logic [31:0]           o_cfg_rdata,
  output cfg_t                  o_cfg
);

  cfg_t cfg_q;

  always_ff @(posedge i_clk) begin
    if (i_rst) begin
      cfg_q.sq_base  <= '0;
      cfg_q.wqe_log2 <= LOG2_W'(WQE_LOG2_MAX);
      cfg_q.quantum  <= QUANT_W'(1);
    end else if (i_cfg_we) begin
      case (i_cfg_addr)
        CFG_ADDR_W'(0): cfg_q.sq_base <= i_cfg_wdata;
        // Clamp to the largest supported WQE size
        CFG_ADDR_W'(1): cfg_q.wqe_log2 <= (i_cfg_wdata > 32'(WQE_LOG2_MAX)) ?
                                          LOG2_W'(WQE_LOG2_MAX) : i_cfg_wdata[LOG2_W-1:0];
        // Zero quantum would stall the scheduler
        CFG_ADDR_W'(2): cfg_q.quantum <= (i_cfg_wdata[QUANT_W-1:0] == '0) ?
                                         QUANT_W'(1) : i_cfg_wdata[QUANT_W-1:0];
        default: ;
      endcase
    end
  end

  always_comb begin
    case (i_cfg_addr)
      CFG_ADDR_W'(0): o_cfg_rdata = cfg_q.sq_base;
      CFG_ADDR_W'(1): o_cfg_rdata = 32'(cfg_q.wqe_log2);
      CFG_ADDR_W'(2): o_cfg_rdata = 32'(cfg_q.quantum);
      default:        o_cfg_rdata = '0;
    endcase
  end

  assign o_cfg = cfg_q;

endmodule

//--- hdl/wqe_indicator_table.sv
`timescale 1ns/1ns

module wqe_indicator_table
  import swp_pkg::*;
(
  input  logic              i_clk,
  input  logic              i_rst,
  input  logic              i_set_en,
  input  logic [QPN_W-1:0]  i_set_qpn,
  input  logic              i_clr_en,
  input  logic [QPN_W-1:0]  i_clr_qpn,
  output logic [NUM_QP-1:0] o_busy
);

  logic [NUM_QP-1:0] busy_q;

  always_ff @(posedge i_clk) begin
    if (i_rst) begin
      busy_q <= '0;
    end else begin
      if (i_clr_en) begin
        busy_q[i_clr_qpn] <= 1'b0;
      end
      if (i_set_en) begin
        busy_q[i_set_qpn] <= 1'b1;
      end
    end
  end

  assign o_busy = busy_q;

endmodule

//--- hdl/doorbell_proc.sv
`timescale 1ns/1ns

module doorbell_proc
  import swp_pkg::*;
(
  input  logic              i_clk,
  input  logic              i_rst,
  input  db_t               i_db,
  input  logic              i_db_valid,
  output logic              o_db_credit,
  input  logic [NUM_QP-1:0] i_busy,
  output logic              o_set_en,
  output logic [QPN_W-1:0]  o_set_qpn,
  output job_t              o_job,
  output logic              o_job_valid
);

  db_t               head;
  logic              head_valid;
  logic              pop;
  logic              lk_valid;
  db_t               lk_db;
  logic              wr_valid;
  db_t               wr_db;
  logic [IDX_W-1:0]  wr_old_pi;
  logic [IDX_W-1:0]  count;
  logic [IDX_W-1:0]  pi_mem [NUM_QP];
  logic [NUM_QP-1:0] pi_seen;

  swp_fifo #(
    .T     (db_t),
    .DEPTH (DB_FIFO_DEPTH)
  ) u_db_fifo (
    .i_clk    (i_clk),
    .i_rst    (i_rst),
    .i_push   (i_db_valid),
    .i_data   (i_db),
    .i_pop    (pop),
    .o_data   (head),
    .o_valid  (head_valid),
    .o_credit (o_db_credit)
  );

  // One doorbell in the lookup/write pipe at a time
  assign pop = head_valid && !lk_valid && !wr_valid && !i_busy[head.qpn];

  always_ff @(posedge i_clk) begin
    if (i_rst) begin
      lk_valid <= 1'b0;
      wr_valid <= 1'b0;
      pi_seen  <= '0;
    end else begin
      lk_valid <= pop;
      wr_valid <= lk_valid;
      if (o_job_valid) begin
        pi_seen[wr_db.qpn] <= 1'b1;
      end
    end
  end

  always_ff @(posedge i_clk) begin
    if (pop) begin
      lk_db <= head;
    end
    wr_db <= lk_db;
    // Entries never written read as zero
    wr_old_pi <= pi_seen[lk_db.qpn] ? pi_mem[lk_db.qpn] : '0;
    if (o_job_valid) begin
      pi_mem[wr_db.qpn] <= wr_db.pi;
    end
  end

  // Wraps modulo 2^16
  assign count = wr_db.pi - wr_old_pi;

  assign o_job_valid = wr_valid && (count != '0);
  assign o_set_en    = o_job_valid;
  assign o_set_qpn   = wr_db.qpn;
  assign o_job       = '{qpn: wr_db.qpn, start: wr_old_pi, count: count};

endmodule

//--- hdl/wqe_scheduler.sv
`timescale 1ns/1ns

module wqe_scheduler
  import swp_pkg::*;
(
  input  logic               i_clk,
  input  logic               i_rst,
  input  job_t               i_job,
  input  logic               i_job_valid,
  input  logic [QUANT_W-1:0] i_quantum,
  input  logic               i_wp_credit,
  output wqe_desc_t          o_wqe,
  output logic               o_wqe_valid
);

  job_t                 head;
  logic                 head_valid;
  logic                 pop;
  logic                 push;
  job_t                 push_job;
  job_t                 act;
  logic                 act_valid;
  logic [QUANT_W-1:0]   act_qleft;
  job_t                 rq_job;
  job_t                 hold_job;
  logic                 hold_valid;
  logic [WP_CRED_W-1:0] credits;
  logic                 emit;
  logic                 last_wqe;
  logic                 q_end;
  logic                 requeue;
  logic                 rq_direct;

  swp_fifo #(
    .T     (job_t),
    .DEPTH (NUM_QP)
  ) u_job_fifo (
    .i_clk    (i_clk),
    .i_rst    (i_rst),
    .i_push   (push),
    .i_data   (push_job),
    .i_pop    (pop),
    .o_data   (head),
    .o_valid  (head_valid),
    .o_credit ()
  );

  assign pop      = head_valid && !act_valid;
  assign emit     = act_valid && (credits != '0);
  assign last_wqe = (act.count == IDX_W'(1));
  assign q_end    = (act_qleft == QUANT_W'(1));
  assign requeue  = emit && !last_wqe && q_end;
  assign rq_job   = '{qpn: act.qpn, start: act.start + 1'b1, count: act.count - 1'b1};

  // New jobs go first, a clashing requeue waits in the holding register
  assign rq_direct = requeue && !i_job_valid && !hold_valid;
  assign push      = i_job_valid || hold_valid || rq_direct;

  always_comb begin
    if (i_job_valid) begin
      push_job = i_job;
    end else if (hold_valid) begin
      push_job = hold_job;
    end else begin
      push_job = rq_job;
    end
  end

  always_ff @(posedge i_clk) begin
    if (i_rst) begin
      act_valid  <= 1'b0;
      hold_valid <= 1'b0;
      credits    <= WP_CRED_W'(WP_FIFO_DEPTH);
    end else begin
      if (pop) begin
        act_valid <= 1'b1;
      end else if (emit && (last_wqe || q_end)) begin
        act_valid <= 1'b0;
      end
      if (requeue && !rq_direct) begin
        hold_valid <= 1'b1;
      end else if (!i_job_valid) begin
        hold_valid <= 1'b0;
      end
      credits <= credits - WP_CRED_W'(emit) + WP_CRED_W'(i_wp_credit);
    end
  end

  always_ff @(posedge i_clk) begin
    if (pop) begin
      act       <= head;
      act_qleft <= i_quantum;
    end else if (emit) begin
      act.start <= act.start + 1'b1;
      act.count <= act.count - 1'b1;
      act_qleft <= act_qleft - 1'b1;
    end
    if (requeue && !rq_direct) begin
      hold_job <= rq_job;
    end
  end

  assign o_wqe       = '{qpn: act.qpn, idx: act.start, last: last_wqe};
  assign o_wqe_valid = emit;

endmodule

//--- hdl/wqe_parser.sv
`timescale 1ns/1ns

module wqe_parser
  import swp_pkg::*;
(
  input  logic              i_clk,
  input  logic              i_rst,
  input  wqe_desc_t         i_wqe,
  input  logic              i_wqe_valid,
  output logic              o_wp_credit,
  input  logic [31:0]       i_sq_base,
  input  logic [LOG2_W-1:0] i_wqe_log2,
  input  logic              i_req_credit,
  output req_t              o_req,
  output logic              o_req_valid,
  output logic              o_clr_en,
  output logic [QPN_W-1:0]  o_clr_qpn
);

  wqe_desc_t             head;
  logic                  head_valid;
  logic                  pop;
  logic [REQ_CRED_W-1:0] credits;
  logic [31:0]           addr;

  swp_fifo #(
    .T     (wqe_desc_t),
    .DEPTH (WP_FIFO_DEPTH)
  ) u_wqe_fifo (
    .i_clk    (i_clk),
    .i_rst    (i_rst),
    .i_push   (i_wqe_valid),
    .i_data   (i_wqe),
    .i_pop    (pop),
    .o_data   (head),
    .o_valid  (head_valid),
    .o_credit (o_wp_credit)
  );

  // Without a credit the head stays in the FIFO
  assign pop = head_valid && (credits != '0);

  // Queue pair region plus ring slot
  assign addr = i_sq_base
              + (32'(head.qpn) << QP_SQ_SHIFT)
              + (32'(head.idx[RING_W-1:0]) << i_wqe_log2);

  always_ff @(posedge i_clk) begin
    if (i_rst) begin
      o_req_valid <= 1'b0;
      credits     <= REQ_CRED_W'(REQ_CREDITS);
    end else begin
      o_req_valid <= pop;
      credits     <= credits - REQ_CRED_W'(pop) + REQ_CRED_W'(i_req_credit);
    end
  end

  always_ff @(posedge i_clk) begin
    if (pop) begin
      o_req <= '{qpn: head.qpn, idx: head.idx, addr: addr, last: head.last};
    end
  end

  // Job done, queue pair may take a new doorbell
  assign o_clr_en  = o_req_valid && o_req.last;
  assign o_clr_qpn = o_req.qpn;

endmodule

//--- hdl/send_wqe_proc.sv
`timescale 1ns/1ns

module send_wqe_proc
  import swp_pkg::*;
(
  input  logic                  i_clk,
  input  logic                  i_rst,
  input  db_t                   i_db,
  input  logic                  i_db_valid,
  output logic                  o_db_credit,
  input  logic                  i_cfg_we,
  input  logic [CFG_ADDR_W-1:0] i_cfg_addr,
  input  logic [31:0]           i_cfg_wdata,
  output logic [31:0]           o_cfg_rdata,
  input  logic                  i_req_credit,
  output req_t                  o_req,
  output logic                  o_req_valid
);

  cfg_t              cfg;
  logic [NUM_QP-1:0] busy;
  logic              set_en;
  logic [QPN_W-1:0]  set_qpn;
  logic              clr_en;
  logic [QPN_W-1:0]  clr_qpn;
  job_t              job;
  logic              job_valid;
  wqe_desc_t         wqe;
  logic              wqe_valid;
  logic              wp_credit;

  swp_cfg_regs u_cfg_regs (
    .i_clk       (i_clk),
    .i_rst       (i_rst),
    .i_cfg_we    (i_cfg_we),
    .i_cfg_addr  (i_cfg_addr),
    .i_cfg_wdata (i_cfg_wdata),
    .o_cfg_rdata (o_cfg_rdata),
    .o_cfg       (cfg)
  );

  wqe_indicator_table u_wqe_indicator_table (
    .i_clk     (i_clk),
    .i_rst     (i_rst),
    .i_set_en  (set_en),
    .i_set_qpn (set_qpn),
    .i_clr_en  (clr_en),
    .i_clr_qpn (clr_qpn),
    .o_busy    (busy)
  );

  doorbell_proc u_doorbell_proc (
    .i_clk       (i_clk),
    .i_rst       (i_rst),
    .i_db        (i_db),
    .i_db_valid  (i_db_valid),
    .o_db_credit (o_db_credit),
    .i_busy      (busy),
    .o_set_en    (set_en),
    .o_set_qpn   (set_qpn),
    .o_job       (job),
    .o_job_valid (job_valid)
  );

  wqe_scheduler u_wqe_scheduler (
    .i_clk       (i_clk),
    .i_rst       (i_rst),
    .i_job       (job),
    .i_job_valid (job_valid),
    .i_quantum   (cfg.quantum),
    .i_wp_credit (wp_credit),
    .o_wqe       (wqe),
    .o_wqe_valid (wqe_valid)
  );

  wqe_parser u_wqe_parser (
    .i_clk        (i_clk),
    .i_rst        (i_rst),
    .i_wqe        (wqe),
    .i_wqe_valid  (wqe_valid),
    .o_wp_credit  (wp_credit),
    .i_sq_base    (cfg.sq_base),
    .i_wqe_log2   (cfg.wqe_log2),
    .i_req_credit (i_req_credit),
    .o_req        (o_req),
    .o_req_valid  (o_req_valid),
    .o_clr_en     (clr_en),
    .o_clr_qpn    (clr_qpn)
  );

endmodule

//--- tb/tb_send_wqe_proc.sv
`timescale 1ns/1ns

module tb_send_wqe_proc
  import swp_pkg::*;
();

  localparam int N_RAND_DB      = 200;
  localparam int N_LONG_DB      = 24;
  localparam int QUIET_CYCLES   = 32;
  localparam int TIMEOUT_CYCLES = 20 * (N_RAND_DB + N_LONG_DB + 2) + 2000;

  logic                  i_clk;
  logic                  i_rst;
  db_t                   i_db;
  logic                  i_db_valid;
  logic                  o_db_credit;
  logic                  i_cfg_we;
  logic [CFG_ADDR_W-1:0] i_cfg_addr;
  logic [31:0]           i_cfg_wdata;
  logic [31:0]           o_cfg_rdata;
  logic                  i_req_credit;
  req_t                  o_req;
  logic                  o_req_valid;

  // Reference model per queue pair
  logic [IDX_W-1:0]  tgt_pi  [NUM_QP] = '{default: '0};
  logic [IDX_W-1:0]  exp_idx [NUM_QP] = '{default: '0};
  logic [IDX_W-1:0]  job_end [NUM_QP][256];
  logic [7:0]        end_wr  [NUM_QP] = '{default: '0};
  logic [7:0]        end_rd  [NUM_QP] = '{default: '0};
  logic [31:0]       cur_base = '0;
  logic [LOG2_W-1:0] cur_log2 = LOG2_W'(6);

  int          db_sent      = 0;
  int          db_returned  = 0;
  int          req_granted  = 0;
  int          req_received = 0;
  int          cycle_cnt    = 0;
  int          hold_left    = 0;
  logic        holding      = 1'b0;
  logic [31:0] lfsr         = 32'hf6a44182;

  send_wqe_proc u_send_wqe_proc (
    .i_clk        (i_clk),
    .i_rst        (i_rst),
    .i_db         (i_db),
    .i_db_valid   (i_db_valid),
    .o_db_credit  (o_db_credit),
    .i_cfg_we     (i_cfg_we),
    .i_cfg_addr   (i_cfg_addr),
    .i_cfg_wdata  (i_cfg_wdata),
    .o_cfg_rdata  (o_cfg_rdata),
    .i_req_credit (i_req_credit),
    .o_req        (o_req),
    .o_req_valid  (o_req_valid)
  );

  initial begin
    i_clk = 1'b0;
    forever #4 i_clk = ~i_clk;
  end

  task automatic abort_run(input string msg);
    $display("%s", msg);
    $display("TEST RESULT: FAIL");
    $fatal(1, "run stopped after a failed check");
  endtask

  task automatic value_error(input string name, input logic [31:0] got, input logic [31:0] exp);
    $display("ERR time=%0t %s got=%0h expected=%0h", $time, name, got, exp);
    abort_run("Value mismatch");
  endtask

  // Taps x^32 + x^22 + x^2 + x + 1 stepped once per bit
  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] v;
    int          i;
    v = '0;
    for (i = 0; i < n; i++) begin
      lfsr = {lfsr[30:0], lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0]};
      v    = {v[30:0], lfsr[0]};
    end
    return v;
  endfunction

  function automatic int outstanding();
    int total;
    int q;
    total = 0;
    for (q = 0; q < NUM_QP; q++) begin
      total += int'(16'(tgt_pi[q] - exp_idx[q]));
    end
    return total;
  endfunction

  task automatic next_cycle();
    logic [31:0] coin;
    @(posedge i_clk);
    #1;
    i_db_valid   = 1'b0;
    i_req_credit = 1'b0;
    // Credit return alternates between busy and silent stretches
    if (hold_left == 0) begin
      hold_left = 16 + int'(rand_bits(6));
      holding   = (rand_bits(2) == 32'd0);
    end
    hold_left--;
    coin = rand_bits(2);
    if (!holding && req_received > req_granted && coin != 32'd0) begin
      i_req_credit = 1'b1;
      req_granted++;
    end
  endtask

  task automatic send_db(input logic [QPN_W-1:0] qpn, input logic [IDX_W-1:0] pi);
    while (db_sent - db_returned >= DB_FIFO_DEPTH) begin
      next_cycle();
    end
    i_db       = '{qpn: qpn, pi: pi};
    i_db_valid = 1'b1;
    db_sent++;
    // Equal pi means no job
    if (pi != tgt_pi[qpn]) begin
      job_end[qpn][end_wr[qpn]] = pi;
      end_wr[qpn]++;
    end
    tgt_pi[qpn] = pi;
    next_cycle();
  endtask

  task automatic cfg_write(input logic [CFG_ADDR_W-1:0] addr, input logic [31:0] data);
    i_cfg_we    = 1'b1;
    i_cfg_addr  = addr;
    i_cfg_wdata = data;
    next_cycle();
    i_cfg_we = 1'b0;
  endtask

  task automatic cfg_check(input logic [CFG_ADDR_W-1:0] addr, input logic [31:0] exp);
    i_cfg_addr = addr;
    next_cycle();
    assert (o_cfg_rdata == exp) else begin
      value_error("o_cfg_rdata", o_cfg_rdata, exp);
    end
  endtask

  task automatic wait_drained();
    while (db_returned != db_sent || outstanding() != 0) begin
      next_cycle();
    end
  endtask

  task automatic check_req(input req_t r);
    logic [IDX_W-1:0] idx;
    logic [31:0]      exp_addr;
    logic             exp_last;
    idx = exp_idx[r.qpn];
    assert (REQ_CREDITS + req_granted - req_received > 0) else begin
      abort_run("o_req_valid fired with no credit granted");
    end
    assert (tgt_pi[r.qpn] != idx) else begin
      abort_run($sformatf("Descriptor for queue pair %0d with nothing outstanding", r.qpn));
    end
    assert (r.idx == idx) else begin
      value_error("o_req.idx", 32'(r.idx), 32'(idx));
    end
    // 16 KiB per queue pair and 256 ring slots
    exp_addr = cur_base + 32'(r.qpn) * 32'd16384 + 32'(idx % 16'd256) * (32'd1 << cur_log2);
    assert (r.addr == exp_addr) else begin
      value_error("o_req.addr", r.addr, exp_addr);
    end
    exp_last = (16'(idx + 16'd1) == job_end[r.qpn][end_rd[r.qpn]]);
    assert (r.last == exp_last) else begin
      value_error("o_req.last", 32'(r.last), 32'(exp_last));
    end
    if (exp_last) begin
      end_rd[r.qpn]++;
    end
    exp_idx[r.qpn] = 16'(idx + 16'd1);
    req_received++;
  endtask

  // Outputs are sampled mid-cycle
  always @(negedge i_clk) begin
    if (!i_rst) begin
      if (o_db_credit) begin
        db_returned++;
      end
      if (o_req_valid) begin
        check_req(o_req);
      end
    end
  end

  always @(posedge i_clk) begin
    cycle_cnt++;
    if (cycle_cnt > TIMEOUT_CYCLES) begin
      abort_run($sformatf("Timeout: run not finished after %0d cycles", TIMEOUT_CYCLES));
    end
  end

  initial begin
    logic [QPN_W-1:0] qpn;
    int               n;
    i_rst        = 1'b1;
    i_db         = '0;
    i_db_valid   = 1'b0;
    i_cfg_we     = 1'b0;
    i_cfg_addr   = '0;
    i_cfg_wdata  = '0;
    i_req_credit = 1'b0;
    repeat (2) @(posedge i_clk);
    #1;
    i_rst = 1'b0;
    assert (!o_req_valid && !o_db_credit) else begin
      abort_run("Outputs not idle after reset");
    end

    // Register write and read-back with clamping
    cfg_write(2'd0, 32'h8001_2000);
    cfg_check(2'd0, 32'h8001_2000);
    cfg_write(2'd1, 32'd7);
    cfg_check(2'd1, 32'd6);
    cfg_write(2'd1, 32'd4);
    cfg_check(2'd1, 32'd4);
    cfg_write(2'd2, 32'd0);
    cfg_check(2'd2, 32'd1);
    cfg_write(2'd2, 32'd3);
    cfg_check(2'd2, 32'd3);
    cfg_check(2'd3, 32'd0);
    cur_base = 32'h8001_2000;
    cur_log2 = LOG2_W'(4);

    // Random doorbells over 8 queue pairs including some with no new WQEs
    for (n = 0; n < N_RAND_DB; n++) begin
      qpn = QPN_W'(rand_bits(3));
      if (rand_bits(2) == 32'd0) begin
        next_cycle();
      end
      send_db(qpn, 16'(tgt_pi[qpn] + 16'(rand_bits(2))));
    end
    wait_drained();

    // Repeated pi only returns a credit
    send_db(6'd3, tgt_pi[3]);
    wait_drained();
    repeat (QUIET_CYCLES) next_cycle();

    // Long jobs split into quanta of 2
    cfg_write(2'd2, 32'd2);
    cfg_check(2'd2, 32'd2);
    cfg_write(2'd1, 32'd6);
    cfg_write(2'd0, 32'h0010_0000);
    cur_log2 = LOG2_W'(6);
    cur_base = 32'h0010_0000;
    for (n = 0; n < N_LONG_DB; n++) begin
      qpn = QPN_W'(rand_bits(2));
      send_db(qpn, 16'(tgt_pi[qpn] + 16'd5 + 16'(rand_bits(3))));
    end
    // Crosses the ring wrap
    send_db(6'd6, 16'(tgt_pi[6] + 16'd260));
    wait_drained();

    // No late credit or descriptor may follow
    repeat (QUIET_CYCLES) next_cycle();
    assert (db_returned == db_sent) else begin
      value_error("db_returned", 32'(db_returned), 32'(db_sent));
    end
    $display("TEST RESULT: PASS");
    $finish;
  end

endmodule

//--- send_wqe_proc.f
hdl/swp_pkg.sv
hdl/swp_fifo.sv
hdl/swp_cfg_regs.sv
hdl/wqe_indicator_table.sv
hdl/doorbell_proc.sv
hdl/wqe_scheduler.sv
hdl/wqe_parser.sv
hdl/send_wqe_proc.sv
tb/tb_send_wqe_proc.sv

//--- Makefile
TOP := tb_send_wqe_proc

.PHONY: run clean

run: obj_dir/V$(TOP)
	./obj_dir/V$(TOP)

obj_dir/V$(TOP): send_wqe_proc.f $(wildcard hdl/*.sv tb/*.sv)
	verilator --binary --timing --assert -Wno-fatal --top-module $(TOP) -f send_wqe_proc.f

clean:
	rm -rf obj_dir
